// File: Makefile
# Verilator build and run of the carrier loop testbench
SIM      ?= verilator
TOP      ?= carrierLoopTb
LOG      ?= sim.log
BUILD    ?= obj_dir
FILELIST ?= carrierLoop.f
SIMFLAGS ?= --binary --assert --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM), run and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "Variables: SIM TOP LOG BUILD FILELIST SIMFLAGS"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test OK" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: carrierLoop.f
hw/carrierLoopPkg.sv
hw/loopCtrlIf.sv
hw/loopRegs.sv
hw/errorAverager.sv
hw/loopFilter.sv
hw/ncoMixer.sv
hw/carrierLoop.sv
tests/carrierLoop_assertions.sv
tests/carrierLoopTb.sv

// File: hw/carrierLoop.sv
/* Carrier recovery loop top level. All strobes are single-cycle, with no
   back-pressure; carrierFreq is also exported for an external lock detector. */
`timescale 1ns/100ps

module carrierLoop import carrierLoopPkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  sample_t              iIn,
    input  sample_t              qIn,
    input  logic                 sampleEn,
    input  error_t               phaseError,
    input  logic                 phaseErrorEn,
    input  logic                 wrEn,
    input  logic [AddrWidth-1:0] addr,
    input  logic [RegWidth-1:0]  din,
    output logic [RegWidth-1:0]  dout,
    output sample_t              iOut,
    output sample_t              qOut,
    output logic                 outEn,
    output freq_t                carrierFreq,
    output logic                 carrierFreqEn
);

    logic [SelectWidth-1:0] averageSelect;
    logic                   invertError;
    logic                   zeroError;
    logic [RegWidth-1:0]    lagAccumRead;
    error_t                 loopError;
    logic                   loopErrorEn;

    loopCtrlIf ctrl ();

    loopRegs regs (
        .clk(clk), .reset(reset),
        .wrEn(wrEn), .addr(addr), .din(din), .dout(dout),
        .lagAccumRead(lagAccumRead),
        .averageSelect(averageSelect),
        .invertError(invertError), .zeroError(zeroError),
        .ctrl(ctrl.regs)
    );

    errorAverager averager (
        .clk(clk), .reset(reset),
        .phaseError(phaseError), .phaseErrorEn(phaseErrorEn),
        .averageSelect(averageSelect),
        .invertError(invertError), .zeroError(zeroError),
        .loopError(loopError), .loopErrorEn(loopErrorEn)
    );

    loopFilter filter (
        .clk(clk), .reset(reset),
        .loopError(loopError), .loopErrorEn(loopErrorEn),
        .ctrl(ctrl.filter),
        .lagAccumRead(lagAccumRead),
        .carrierFreq(carrierFreq), .carrierFreqEn(carrierFreqEn)
    );

    ncoMixer mixer (
        .clk(clk), .reset(reset),
        .iIn(iIn), .qIn(qIn), .sampleEn(sampleEn),
        .carrierFreq(carrierFreq),
        .iOut(iOut), .qOut(qOut), .outEn(outEn)
    );

endmodule

// File: hw/carrierLoopPkg.sv
/* Widths, register map and the 16-point sine table of the carrier loop.
   The coarse table limits derotation accuracy to about 22.5 degrees of phase. */
package carrierLoopPkg;

    // Data widths
    localparam int SampleWidth    = 18;
    localparam int ErrorWidth     = 8;
    localparam int AccumWidth     = 40;
    localparam int FreqWidth      = 32;
    localparam int ExpWidth       = 5;
    localparam int SumWidth       = 16;
    localparam int CountWidth     = 7;
    localparam int SelectWidth    = 3;
    localparam int RegWidth       = 32;
    localparam int AddrWidth      = 4;
    localparam int SineIndexWidth = 4;

    typedef logic signed [SampleWidth-1:0] sample_t;
    typedef logic signed [ErrorWidth-1:0]  error_t;
    typedef logic signed [AccumWidth-1:0]  accum_t;
    typedef logic signed [FreqWidth-1:0]   freq_t;

    // Register map
    localparam logic [AddrWidth-1:0] AddrControl  = 4'd0;
    localparam logic [AddrWidth-1:0] AddrLeadExp  = 4'd1;
    localparam logic [AddrWidth-1:0] AddrLagExp   = 4'd2;
    localparam logic [AddrWidth-1:0] AddrLimit    = 4'd3;
    localparam logic [AddrWidth-1:0] AddrLagAccum = 4'd4;

    // 131071 * sin(k * 22.5 deg), cosine is index + 4
    localparam sample_t SineTable [2**SineIndexWidth] = '{
        18'sd0,       18'sd50159,   18'sd92681,   18'sd121094,
        18'sd131071,  18'sd121094,  18'sd92681,   18'sd50159,
        18'sd0,      -18'sd50159,  -18'sd92681,  -18'sd121094,
       -18'sd131071, -18'sd121094, -18'sd92681,  -18'sd50159
    };

endpackage

// File: hw/errorAverager.sv
/* Averages 2**averageSelect phase errors per loop strobe. A change of
   averageSelect restarts the count and the sum; the rounded average saturates. */
`timescale 1ns/100ps

module errorAverager import carrierLoopPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  error_t                 phaseError,
    input  logic                   phaseErrorEn,
    input  logic [SelectWidth-1:0] averageSelect,
    input  logic                   invertError,
    input  logic                   zeroError,
    output error_t                 loopError,
    output logic                   loopErrorEn
);

    logic signed [SumWidth-1:0] errorSum;
    logic signed [SumWidth-1:0] shiftError;
    logic signed [SumWidth-1:0] baseSum;
    logic signed [SumWidth-1:0] nextSum;
    logic [CountWidth-1:0]      avgCounter;
    logic [CountWidth-1:0]      countLoad;
    logic [CountWidth-1:0]      countNow;
    logic [SelectWidth-1:0]     lastSelect;
    logic                       selectChanged;
    logic                       terminalCount;
    error_t                     upperSum;
    error_t                     roundedSum;

    // Sample placed in the top byte, then scaled by 1/N
    assign shiftError = $signed({phaseError, {(SumWidth-ErrorWidth){1'b0}}}) >>> averageSelect;
    assign countLoad  = CountWidth'((1 << averageSelect) - 1);

    // A fresh select acts as if the counter had just been reloaded
    assign selectChanged = (averageSelect != lastSelect);
    assign countNow      = selectChanged ? countLoad : avgCounter;
    assign baseSum       = selectChanged ? '0 : errorSum;
    assign terminalCount = (countNow == '0);
    assign nextSum       = invertError ? baseSum - shiftError : baseSum + shiftError;

    // Round half up, held at +127 instead of wrapping
    always_comb begin
        upperSum = nextSum[SumWidth-1 -: ErrorWidth];
        if (nextSum[SumWidth-ErrorWidth-1] && upperSum != {1'b0, {(ErrorWidth-1){1'b1}}}) begin
            roundedSum = upperSum + error_t'(1);
        end else begin
            roundedSum = upperSum;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            avgCounter  <= '0;
            lastSelect  <= '0;
            errorSum    <= '0;
            loopError   <= '0;
            loopErrorEn <= 1'b0;
        end else begin
            lastSelect  <= averageSelect;
            loopErrorEn <= phaseErrorEn && terminalCount;
            if (phaseErrorEn && terminalCount) begin
                avgCounter <= countLoad;
                errorSum   <= '0;
                loopError  <= zeroError ? '0 : roundedSum;
            end else if (phaseErrorEn) begin
                avgCounter <= countNow - 1'b1;
                errorSum   <= zeroError ? '0 : nextSum;
            end else if (selectChanged) begin
                avgCounter <= countLoad;
                errorSum   <= '0;
            end
        end
    end

endmodule

// File: hw/loopCtrlIf.sv
/* Loop filter controls. All fields are levels held by the register file
   and may change at any time between error strobes. */
`timescale 1ns/100ps

interface loopCtrlIf import carrierLoopPkg::*; ();

    // Gain exponents, shift left of the loop error
    logic [ExpWidth-1:0] leadExp;
    logic [ExpWidth-1:0] lagExp;

    // Positive clamp for lag accumulator bits 39:8
    logic [RegWidth-1:0] limit;

    // Holds the lag accumulator at zero while set
    logic                clearAccum;

    modport regs (
        output leadExp,
        output lagExp,
        output limit,
        output clearAccum
    );

    modport filter (
        input  leadExp,
        input  lagExp,
        input  limit,
        input  clearAccum
    );

endinterface

// File: hw/loopFilter.sv
/* Lead/lag loop filter. The lag accumulator is clamped to +-limit on bits 39:8;
   the final lead plus lag sum wraps, so keep limit and gains within range. */
`timescale 1ns/100ps

module loopFilter import carrierLoopPkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  error_t              loopError,
    input  logic                loopErrorEn,
    loopCtrlIf.filter           ctrl,
    output logic [RegWidth-1:0] lagAccumRead,
    output freq_t               carrierFreq,
    output logic                carrierFreqEn
);

    accum_t                         lagAccum;
    accum_t                         filterSum;
    accum_t                         errorExt;
    accum_t                         leadTerm;
    accum_t                         lagStep;
    accum_t                         lagNext;
    accum_t                         lagHeld;
    logic signed [AccumWidth:0]     lagSum;
    logic signed [FreqWidth:0]      lagUpper;
    logic signed [FreqWidth:0]      posLimit;
    logic signed [FreqWidth:0]      negLimit;

    // --------------------
    // Gains
    assign errorExt = accum_t'(loopError);
    assign leadTerm = errorExt <<< ctrl.leadExp;
    assign lagStep  = errorExt <<< ctrl.lagExp;

    // One guard bit so the clamp sees a true overflow
    assign lagSum   = (AccumWidth+1)'(lagAccum) + (AccumWidth+1)'(lagStep);
    assign lagUpper = lagSum[AccumWidth -: FreqWidth+1];
    assign posLimit = $signed({1'b0, ctrl.limit});
    assign negLimit = -posLimit;

    // --------------------
    // Lag clamp
    always_comb begin
        if (lagUpper > posLimit) begin
            lagNext = accum_t'({ctrl.limit, {(AccumWidth-FreqWidth){1'b0}}});
        end else if (lagUpper < negLimit) begin
            lagNext = accum_t'({negLimit[FreqWidth-1:0], {(AccumWidth-FreqWidth){1'b0}}});
        end else begin
            lagNext = lagSum[AccumWidth-1:0];
        end
    end

    assign lagHeld = ctrl.clearAccum ? '0 : lagNext;

    always_ff @(posedge clk) begin
        if (reset) begin
            lagAccum      <= '0;
            filterSum     <= '0;
            carrierFreqEn <= 1'b0;
        end else begin
            carrierFreqEn <= loopErrorEn;
            if (ctrl.clearAccum) begin
                lagAccum <= '0;
            end else if (loopErrorEn) begin
                lagAccum <= lagNext;
            end
            if (loopErrorEn) begin
                filterSum <= lagHeld + leadTerm;
            end
        end
    end

    assign lagAccumRead = lagAccum[AccumWidth-1 -: RegWidth];
    assign carrierFreq  = filterSum[AccumWidth-1 -: FreqWidth];

endmodule

// File: hw/loopRegs.sv
/* Loop control registers. Writes land on the edge with wrEn high; dout follows
   addr combinationally. Unmapped addresses read as zero and ignore writes. */
`timescale 1ns/100ps

module loopRegs import carrierLoopPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   wrEn,
    input  logic [AddrWidth-1:0]   addr,
    input  logic [RegWidth-1:0]    din,
    output logic [RegWidth-1:0]    dout,
    input  logic [RegWidth-1:0]    lagAccumRead,
    output logic [SelectWidth-1:0] averageSelect,
    output logic                   invertError,
    output logic                   zeroError,
    loopCtrlIf.regs                ctrl
);

    logic [ExpWidth-1:0] leadExp;
    logic [ExpWidth-1:0] lagExp;
    logic [RegWidth-1:0] limit;
    logic                clearAccum;

    // --------------------
    // Write decode
    always_ff @(posedge clk) begin
        if (reset) begin
            invertError   <= 1'b0;
            zeroError     <= 1'b0;
            clearAccum    <= 1'b0;
            averageSelect <= '0;
            leadExp       <= '0;
            lagExp        <= '0;
            limit         <= '0;
        end else if (wrEn) begin
            case (addr)
                AddrControl: begin
                    invertError   <= din[0];
                    zeroError     <= din[1];
                    clearAccum    <= din[2];
                    averageSelect <= din[6:4];
                end
                AddrLeadExp: leadExp <= din[ExpWidth-1:0];
                AddrLagExp:  lagExp  <= din[ExpWidth-1:0];
                AddrLimit:   limit   <= din;
                default: ;
            endcase
        end
    end

    assign ctrl.leadExp    = leadExp;
    assign ctrl.lagExp     = lagExp;
    assign ctrl.limit      = limit;
    assign ctrl.clearAccum = clearAccum;

    // --------------------
    // Readback, lag accumulator is live
    always_comb begin
        dout = '0;
        case (addr)
            AddrControl:  dout[6:0] = {averageSelect, 1'b0, clearAccum, zeroError, invertError};
            AddrLeadExp:  dout[ExpWidth-1:0] = leadExp;
            AddrLagExp:   dout[ExpWidth-1:0] = lagExp;
            AddrLimit:    dout = limit;
            AddrLagAccum: dout = lagAccumRead;
            default:      dout = '0;
        endcase
    end

endmodule

// File: hw/ncoMixer.sv
/* NCO and complex derotation, two cycles from sampleEn to outEn. The phase only
   advances on sampleEn, so carrierFreq is a per-sample phase step. */
`timescale 1ns/100ps

module ncoMixer import carrierLoopPkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  sample_t iIn,
    input  sample_t qIn,
    input  logic    sampleEn,
    input  freq_t   carrierFreq,
    output sample_t iOut,
    output sample_t qOut,
    output logic    outEn
);

    logic [FreqWidth-1:0]           phase;
    logic [SineIndexWidth-1:0]      sinIndex;
    logic [SineIndexWidth-1:0]      cosIndex;
    sample_t                        cosReg;
    sample_t                        sinReg;
    sample_t                        iReg;
    sample_t                        qReg;
    logic                           stageEn;
    logic signed [2*SampleWidth:0]  iSum;
    logic signed [2*SampleWidth:0]  qSum;

    // Round at bit 16, drop 17 bits, clip to 18-bit range
    function automatic sample_t roundSat(input logic signed [2*SampleWidth:0] value);
        logic signed [2*SampleWidth:0] shifted;
        shifted = (value + (1 <<< (SampleWidth-2))) >>> (SampleWidth-1);
        if (shifted > (1 <<< (SampleWidth-1)) - 1) begin
            roundSat = {1'b0, {(SampleWidth-1){1'b1}}};
        end else if (shifted < -(1 <<< (SampleWidth-1))) begin
            roundSat = {1'b1, {(SampleWidth-1){1'b0}}};
        end else begin
            roundSat = shifted[SampleWidth-1:0];
        end
    endfunction

    // Lookup uses the phase before this sample's update
    assign sinIndex = phase[FreqWidth-1 -: SineIndexWidth];
    assign cosIndex = sinIndex + SineIndexWidth'(2**(SineIndexWidth-2));

    // (i + jq) * (cos - j sin)
    assign iSum = iReg * cosReg + qReg * sinReg;
    assign qSum = qReg * cosReg - iReg * sinReg;

    // --------------------
    // Phase and strobes
    always_ff @(posedge clk) begin
        if (reset) begin
            phase   <= '0;
            stageEn <= 1'b0;
            outEn   <= 1'b0;
        end else begin
            stageEn <= sampleEn;
            outEn   <= stageEn;
            if (sampleEn) begin
                phase <= phase + carrierFreq;
            end
        end
    end

    // Data pipeline
    always_ff @(posedge clk) begin
        if (sampleEn) begin
            cosReg <= SineTable[cosIndex];
            sinReg <= SineTable[sinIndex];
            iReg   <= iIn;
            qReg   <= qIn;
        end
        if (stageEn) begin
            iOut <= roundSat(iSum);
            qOut <= roundSat(qSum);
        end
    end

endmodule

// File: tests/carrierLoopTb.sv
/* Testbench for carrierLoop. Strobes are sent one group at a time, so each
   expected value is checked before the next group starts. */
`timescale 1ns/100ps

module carrierLoopTb import carrierLoopPkg::*; ();

    logic clk = 1'b0;
    logic reset;
    sample_t iIn, qIn;
    logic sampleEn, phaseErrorEn, wrEn;
    error_t phaseError;
    logic [AddrWidth-1:0] addr;
    logic [RegWidth-1:0] din, dout;
    sample_t iOut, qOut;
    logic outEn, carrierFreqEn;
    freq_t carrierFreq;

    // Reference state
    logic [31:0] rngState = 32'd54;
    longint lagModel;
    longint limitModel;
    freq_t freqModel;
    logic [31:0] phaseModel;
    int sineRef[16];
    int leadExpModel, lagExpModel, selModel;
    bit invModel, zeroModel, clearModel;

    carrierLoop DUT (.*);

    bind carrierLoop carrierLoopAssertions checks (
        .clk(clk), .reset(reset), .sampleEn(sampleEn), .outEn(outEn),
        .loopErrorEn(loopErrorEn), .carrierFreqEn(carrierFreqEn),
        .carrierFreq(carrierFreq), .lagAccumRead(lagAccumRead), .limit(ctrl.limit)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic longint saturate18(longint v);
        if (v > 131071) return 131071;
        if (v < -131072) return -131072;
        return v;
    endfunction

    task automatic reportMismatch(string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic checkEqual(string what, longint got, longint expected);
        assert (got == expected) else
            reportMismatch($sformatf("%s is %0h, expected %0h", what, got, expected));
    endtask

    task automatic stopOnTimeout(string msg);
        $display("Timed out: %s", msg);
        $display("Test FAILED");
        $fatal(1, "wait timed out");
    endtask

    // --------------------
    // Register bus
    task automatic writeReg(logic [AddrWidth-1:0] a, logic [31:0] d);
        @(posedge clk);
        wrEn <= 1'b1;
        addr <= a;
        din  <= d;
        @(posedge clk);
        wrEn <= 1'b0;
    endtask

    task automatic readExpect(logic [AddrWidth-1:0] a, logic [31:0] expected);
        @(posedge clk);
        addr <= a;
        @(negedge clk);
        checkEqual($sformatf("dout at address %0d", a), dout, expected);
    endtask

    task automatic setControl(int sel, bit inv, bit zero, bit clr);
        writeReg(AddrControl, {25'b0, 3'(sel), 1'b0, clr, zero, inv});
        selModel   = sel;
        invModel   = inv;
        zeroModel  = zero;
        clearModel = clr;
        if (clr) lagModel = 0;
    endtask

    task automatic waitFreqStrobe();
        int count;
        count = 0;
        do begin
            @(negedge clk);
            count++;
            if (count > 40) stopOnTimeout("no carrierFreqEn after error group");
        end while (!carrierFreqEn);
    endtask

    // One averaged loop error, then the filter update and checks
    task automatic runGroup(bit useConst, int constVal);
        int total, e, avg;
        longint lead, sum;
        total = 0;
        for (int k = 0; k < (1 << selModel); k++) begin
            e = useConst ? constVal : int'(xorshift() % 255) - 127;
            @(posedge clk);
            phaseError   <= error_t'(e);
            phaseErrorEn <= 1'b1;
            if (invModel) total -= (e * 256) >>> selModel;
            else total += (e * 256) >>> selModel;
        end
        @(posedge clk);
        phaseErrorEn <= 1'b0;
        avg = (total + 128) >>> 8;
        if (avg > 127) avg = 127;
        if (zeroModel) avg = 0;
        if (!clearModel) begin
            sum = lagModel + (longint'(avg) <<< lagExpModel);
            if ((sum >>> 8) > limitModel) lagModel = limitModel * 256;
            else if ((sum >>> 8) < -limitModel) lagModel = -limitModel * 256;
            else lagModel = sum;
        end
        lead = longint'(avg) <<< leadExpModel;
        freqModel = 32'((lagModel + lead) >>> 8);
        waitFreqStrobe();
        checkEqual("carrierFreq", carrierFreq, freqModel);
        readExpect(AddrLagAccum, 32'(lagModel >>> 8));
    endtask

    // --------------------
    // Mixer
    task automatic sendSample(int iv, int qv);
        int idx, c, s, count;
        longint iExp, qExp;
        idx = phaseModel[31:28];
        s = sineRef[idx];
        c = sineRef[(idx + 4) % 16];
        iExp = saturate18((longint'(iv) * c + longint'(qv) * s + 65536) >>> 17);
        qExp = saturate18((longint'(qv) * c - longint'(iv) * s + 65536) >>> 17);
        phaseModel = phaseModel + freqModel;
        @(posedge clk);
        iIn <= sample_t'(iv);
        qIn <= sample_t'(qv);
        sampleEn <= 1'b1;
        @(posedge clk);
        sampleEn <= 1'b0;
        count = 0;
        do begin
            @(negedge clk);
            count++;
            if (count > 10) stopOnTimeout("no outEn after sampleEn");
        end while (!outEn);
        checkEqual("iOut", iOut, iExp);
        checkEqual("qOut", qOut, qExp);
    endtask

    task automatic runSamples(int n);
        for (int k = 0; k < n; k++) begin
            sendSample(int'(xorshift() % 262143) - 131071, int'(xorshift() % 262143) - 131071);
        end
    endtask

    initial begin
        for (int k = 0; k < 16; k++) begin
            sineRef[k] = int'(131071.0 * $sin(k * 3.141592653589793 / 8.0));
        end
        reset = 1'b1;
        {iIn, qIn, sampleEn, phaseError, phaseErrorEn, wrEn, addr, din} = '0;
        {lagModel, limitModel, freqModel, phaseModel} = '0;
        {leadExpModel, lagExpModel, selModel} = '0;
        {invModel, zeroModel, clearModel} = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // Zero phase first, output close to the input
        runSamples(8);

        // Register readback
        writeReg(AddrLeadExp, 32'd4);
        writeReg(AddrLagExp, 32'd6);
        writeReg(AddrLimit, 32'h0010_0000);
        leadExpModel = 4;
        lagExpModel = 6;
        limitModel = 64'h0010_0000;
        readExpect(AddrLeadExp, 32'd4);
        readExpect(AddrLagExp, 32'd6);
        readExpect(AddrLimit, 32'h0010_0000);
        readExpect(AddrLagAccum, 32'd0);

        // Averaging counts 1, 2, 4 and 8
        for (int sel = 0; sel < 4; sel++) begin
            setControl(sel, 0, 0, 0);
            readExpect(AddrControl, 32'(sel << 4));
            repeat (3) runGroup(0, 0);
        end

        // Lag clamp with a small limit
        setControl(0, 0, 0, 1);
        readExpect(AddrControl, 32'h04);
        readExpect(AddrLagAccum, 32'd0);
        writeReg(AddrLimit, 32'd1000);
        writeReg(AddrLagExp, 32'd16);
        limitModel = 1000;
        lagExpModel = 16;
        setControl(0, 0, 0, 0);
        repeat (4) runGroup(1, 120);

        // Zeroed, inverted, then cleared
        setControl(0, 0, 1, 0);
        readExpect(AddrControl, 32'h02);
        runGroup(1, 50);
        setControl(0, 1, 0, 0);
        repeat (2) runGroup(1, 50);
        setControl(1, 1, 0, 0);
        readExpect(AddrControl, 32'h11);
        runGroup(0, 0);
        setControl(0, 0, 0, 1);
        readExpect(AddrLagAccum, 32'd0);

        // Large lag gives a carrierFreq of a sixteenth turn per sample
        writeReg(AddrLimit, 32'h1000_0000);
        writeReg(AddrLagExp, 32'd28);
        writeReg(AddrLeadExp, 32'd0);
        limitModel = 64'h1000_0000;
        lagExpModel = 28;
        leadExpModel = 0;
        setControl(0, 0, 0, 0);
        repeat (4) runGroup(1, 100);
        runSamples(12);

        repeat (4) @(posedge clk);
        if (DUT.checks.failCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: tests/carrierLoop_assertions.sv
/* Strobe latency, lag clamp and reset state checks, bound to carrierLoop.
   The clamp is checked when carrierFreqEn shows a fresh accumulator value. */
`timescale 1ns/100ps

module carrierLoopAssertions (
    input logic        clk,
    input logic        reset,
    input logic        sampleEn,
    input logic        outEn,
    input logic        loopErrorEn,
    input logic        carrierFreqEn,
    input logic [31:0] carrierFreq,
    input logic [31:0] lagAccumRead,
    input logic [31:0] limit
);

    logic signed [32:0] lagExt;
    logic signed [32:0] limitExt;

    // Number of failed checks so far
    int failCount = 0;

    assign lagExt   = {lagAccumRead[31], lagAccumRead};
    assign limitExt = {1'b0, limit};

    // --------------------
    // Strobe timing
    freqFollowsLoop: assert property (@(posedge clk) disable iff (reset)
        loopErrorEn |=> carrierFreqEn)
        else begin
            failCount++;
            $error("carrierFreqEn missing after loop strobe");
        end
    freqOnlyAfterLoop: assert property (@(posedge clk) disable iff (reset)
        carrierFreqEn |-> $past(loopErrorEn))
        else begin
            failCount++;
            $error("carrierFreqEn without loop strobe");
        end
    outLatency: assert property (@(posedge clk) disable iff (reset)
        sampleEn |-> ##2 outEn)
        else begin
            failCount++;
            $error("outEn not two cycles after sampleEn");
        end
    outOnlyAfterSample: assert property (@(posedge clk) disable iff (reset)
        outEn |-> $past(sampleEn, 2))
        else begin
            failCount++;
            $error("outEn without sampleEn");
        end

    // Lag clamp
    lagWithinLimit: assert property (@(posedge clk) disable iff (reset)
        carrierFreqEn |-> (lagExt <= limitExt && lagExt >= -limitExt))
        else begin
            failCount++;
            $error("lag accumulator outside limit");
        end

    // Reset state
    resetState: assert property (@(posedge clk)
        reset |=> (!outEn && !carrierFreqEn && carrierFreq == '0))
        else begin
            failCount++;
            $error("outputs not cleared by reset");
        end

endmodule
